// ==== design/conv_pkg.sv ====
package conv_pkg;

	// Signed fixed-point widths.
	localparam int PIXEL_WIDTH = 8;
	localparam int WEIGHT_WIDTH = 8;
	localparam int PRODUCT_WIDTH = PIXEL_WIDTH + WEIGHT_WIDTH;

	// Nine full-scale products need four bits of growth.
	localparam int SUM_WIDTH = 20;

	// Image and kernel geometry.
	localparam int IFM_SIZE = 8;
	localparam int KERNEL_SIZE = 3;
	localparam int NUM_TAPS = KERNEL_SIZE * KERNEL_SIZE;
	localparam int OFM_SIZE = IFM_SIZE - KERNEL_SIZE + 1;

	// Two full rows plus the last kernel row.
	localparam int WINDOW_DEPTH = (KERNEL_SIZE - 1) * IFM_SIZE + KERNEL_SIZE;

	localparam int WEIGHT_ADDR_WIDTH = $clog2(NUM_TAPS);

	// Adder levels to reduce NUM_TAPS operands to one.
	localparam int TREE_STAGES = $clog2(NUM_TAPS);

	// Product register plus the adder levels.
	localparam int CONV_LATENCY = 1 + TREE_STAGES;

endpackage

// ==== design/window_buffer.sv ====
`timescale 1ns/1ns

module window_buffer
(
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   pixel_valid,
	input  logic signed [conv_pkg::PIXEL_WIDTH-1:0] pixel_in,
	output logic signed [conv_pkg::PIXEL_WIDTH-1:0] taps [conv_pkg::NUM_TAPS]
);

	// Entry 0 holds the newest pixel.
	logic signed [conv_pkg::PIXEL_WIDTH-1:0] shift_line [conv_pkg::WINDOW_DEPTH];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < conv_pkg::WINDOW_DEPTH; i++)
				shift_line[i] <= '0;
		end
		else if (pixel_valid)
		begin
			shift_line[0] <= pixel_in;
			for (int i = 1; i < conv_pkg::WINDOW_DEPTH; i++)
				shift_line[i] <= shift_line[i-1];
		end
	end

	// Tap r*K+c sits r rows and c columns from the top-left corner.
	// The newest pixel is the bottom-right corner of the window.
	for (genvar r = 0; r < conv_pkg::KERNEL_SIZE; r++)
	begin : g_row
		for (genvar c = 0; c < conv_pkg::KERNEL_SIZE; c++)
		begin : g_col
			assign taps[r*conv_pkg::KERNEL_SIZE + c] =
				shift_line[(conv_pkg::KERNEL_SIZE - 1 - r) * conv_pkg::IFM_SIZE
					+ (conv_pkg::KERNEL_SIZE - 1 - c)];
		end
	end

endmodule

// ==== design/weight_bank.sv ====
`timescale 1ns/1ns

module weight_bank
(
	input  logic                                         clk,
	input  logic                                         reset,
	input  logic                                         weight_we,
	input  logic        [conv_pkg::WEIGHT_ADDR_WIDTH-1:0] weight_addr,
	input  logic signed [conv_pkg::WEIGHT_WIDTH-1:0]      weight_data,
	output logic signed [conv_pkg::WEIGHT_WIDTH-1:0]      weights [conv_pkg::NUM_TAPS]
);

	logic addr_ok;

	// Indices past the last tap are dropped.
	assign addr_ok = int'(weight_addr) < conv_pkg::NUM_TAPS;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < conv_pkg::NUM_TAPS; i++)
				weights[i] <= '0;
		end
		else if (weight_we && addr_ok)
		begin
			weights[weight_addr] <= weight_data;
		end
	end

endmodule

// ==== design/conv_ctrl.sv ====
`timescale 1ns/1ns

module conv_ctrl
(
	input  logic clk,
	input  logic reset,
	input  logic pixel_valid,
	output logic window_ready,
	output logic out_valid,
	output logic frame_done
);

	logic [$clog2(conv_pkg::IFM_SIZE)-1:0] col;
	logic [$clog2(conv_pkg::IFM_SIZE)-1:0] row;
	logic                                  col_last;
	logic                                  row_last;
	logic                                  last_pos;
	logic [conv_pkg::TREE_STAGES:0]        valid_line;
	logic [conv_pkg::TREE_STAGES:0]        done_line;

	assign col_last = col == conv_pkg::IFM_SIZE - 1;
	assign row_last = row == conv_pkg::IFM_SIZE - 1;

	// Position of the next pixel; wraps so frames follow each other freely.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			col <= '0;
			row <= '0;
		end
		else if (pixel_valid)
		begin
			if (col_last)
			begin
				col <= '0;
				row <= row_last ? '0 : row + 1'b1;
			end
			else
				col <= col + 1'b1;
		end
	end

	// A full window exists once both coordinates reach the kernel edge.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			window_ready <= 1'b0;
			last_pos     <= 1'b0;
			valid_line   <= '0;
			done_line    <= '0;
		end
		else
		begin
			window_ready <= pixel_valid && col >= conv_pkg::KERNEL_SIZE - 1
				&& row >= conv_pkg::KERNEL_SIZE - 1;
			last_pos     <= pixel_valid && col_last && row_last;
			valid_line   <= {valid_line[conv_pkg::TREE_STAGES-1:0], window_ready};
			done_line    <= {done_line[conv_pkg::TREE_STAGES-1:0], last_pos};
		end
	end

	// Matches the product register plus the adder levels.
	assign out_valid  = valid_line[conv_pkg::TREE_STAGES];
	assign frame_done = done_line[conv_pkg::TREE_STAGES];

endmodule

// ==== design/conv_unit.sv ====
`timescale 1ns/1ns

module conv_unit
(
	input  logic                                    clk,
	input  logic                                    reset,
	input  logic                                    conv_enable,
	input  logic signed [conv_pkg::PIXEL_WIDTH-1:0]  taps [conv_pkg::NUM_TAPS],
	input  logic signed [conv_pkg::WEIGHT_WIDTH-1:0] weights [conv_pkg::NUM_TAPS],
	output logic signed [conv_pkg::SUM_WIDTH-1:0]    conv_data_out
);

	typedef logic signed [conv_pkg::PRODUCT_WIDTH-1:0] prod_t;
	typedef logic signed [conv_pkg::SUM_WIDTH-1:0]     sum_t;

	prod_t prod [conv_pkg::NUM_TAPS];
	sum_t  lvl1 [5];
	sum_t  lvl2 [3];
	sum_t  lvl3 [2];
	sum_t  lvl4;

	// Products are held while no new window is offered.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < conv_pkg::NUM_TAPS; i++)
				prod[i] <= '0;
		end
		else if (conv_enable)
		begin
			for (int i = 0; i < conv_pkg::NUM_TAPS; i++)
				prod[i] <= prod_t'(taps[i]) * prod_t'(weights[i]);
		end
	end

	// Adder tree of 9, 5, 3, 2 and 1 operands with the odd one carried forward.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < 5; i++)
				lvl1[i] <= '0;
			for (int i = 0; i < 3; i++)
				lvl2[i] <= '0;
			lvl3[0] <= '0;
			lvl3[1] <= '0;
			lvl4    <= '0;
		end
		else
		begin
			for (int i = 0; i < 4; i++)
				lvl1[i] <= sum_t'(prod[2*i]) + sum_t'(prod[2*i+1]);
			lvl1[4] <= sum_t'(prod[8]);

			for (int i = 0; i < 2; i++)
				lvl2[i] <= lvl1[2*i] + lvl1[2*i+1];
			lvl2[2] <= lvl1[4];

			lvl3[0] <= lvl2[0] + lvl2[1];
			lvl3[1] <= lvl2[2];

			lvl4 <= lvl3[0] + lvl3[1];
		end
	end

	assign conv_data_out = lvl4;

endmodule

// ==== design/conv_top.sv ====
`timescale 1ns/1ns

module conv_top
(
	input  logic                                         clk,
	input  logic                                         reset,
	input  logic                                         weight_we,
	input  logic        [conv_pkg::WEIGHT_ADDR_WIDTH-1:0] weight_addr,
	input  logic signed [conv_pkg::WEIGHT_WIDTH-1:0]      weight_data,
	input  logic                                         pixel_valid,
	input  logic signed [conv_pkg::PIXEL_WIDTH-1:0]       pixel_in,
	output logic                                         out_valid,
	output logic signed [conv_pkg::SUM_WIDTH-1:0]         out_data,
	output logic                                         frame_done
);

	logic signed [conv_pkg::PIXEL_WIDTH-1:0]  taps [conv_pkg::NUM_TAPS];
	logic signed [conv_pkg::WEIGHT_WIDTH-1:0] weights [conv_pkg::NUM_TAPS];
	logic                                     window_ready;

	window_buffer window_buffer (
		.clk         (clk),
		.reset       (reset),
		.pixel_valid (pixel_valid),
		.pixel_in    (pixel_in),
		.taps        (taps)
	);

	weight_bank weight_bank (
		.clk         (clk),
		.reset       (reset),
		.weight_we   (weight_we),
		.weight_addr (weight_addr),
		.weight_data (weight_data),
		.weights     (weights)
	);

	conv_ctrl conv_ctrl (
		.clk          (clk),
		.reset        (reset),
		.pixel_valid  (pixel_valid),
		.window_ready (window_ready),
		.out_valid    (out_valid),
		.frame_done   (frame_done)
	);

	// The window qualifier doubles as the product register load.
	conv_unit conv_unit (
		.clk           (clk),
		.reset         (reset),
		.conv_enable   (window_ready),
		.taps          (taps),
		.weights       (weights),
		.conv_data_out (out_data)
	);

endmodule

// ==== verif/conv_chk.sv ====
`timescale 1ns/1ns

module conv_chk
(
	input logic clk,
	input logic reset,
	input logic window_ready,
	input logic out_valid,
	input logic frame_done
);

	// Product register plus four adder levels.
	property valid_follows_window;
		@(posedge clk) disable iff (reset)
		out_valid == $past(window_ready, conv_pkg::CONV_LATENCY);
	endproperty

	property done_with_valid;
		@(posedge clk) disable iff (reset)
		frame_done |-> out_valid;
	endproperty

	property quiet_in_reset;
		@(posedge clk)
		reset |-> !out_valid && !window_ready && !frame_done;
	endproperty

	a_valid_follows_window: assert property (valid_follows_window)
		else $error("out_valid does not follow window_ready");
	a_done_with_valid: assert property (done_with_valid)
		else $error("frame_done without out_valid");
	a_quiet_in_reset: assert property (quiet_in_reset)
		else $error("control output high during reset");

endmodule

bind conv_ctrl conv_chk conv_chk (
	.clk          (clk),
	.reset        (reset),
	.window_ready (window_ready),
	.out_valid    (out_valid),
	.frame_done   (frame_done)
);

// ==== verif/conv_tb.sv ====
`timescale 1ns/1ns

module conv_tb;

	localparam int NUM_FRAMES = 6;
	localparam int FRAME_RESULTS = conv_pkg::OFM_SIZE * conv_pkg::OFM_SIZE;
	localparam int TOTAL_RESULTS = NUM_FRAMES * FRAME_RESULTS;
	localparam int WATCHDOG_CYCLES = NUM_FRAMES * 64 * 4 + 200;

	logic                                         clk;
	logic                                         reset;
	logic                                         weight_we;
	logic        [conv_pkg::WEIGHT_ADDR_WIDTH-1:0] weight_addr;
	logic signed [conv_pkg::WEIGHT_WIDTH-1:0]      weight_data;
	logic                                         pixel_valid;
	logic signed [conv_pkg::PIXEL_WIDTH-1:0]       pixel_in;
	logic                                         out_valid;
	logic signed [conv_pkg::SUM_WIDTH-1:0]         out_data;
	logic                                         frame_done;

	logic [15:0] lfsr_state = 16'd77;
	int          image [conv_pkg::IFM_SIZE][conv_pkg::IFM_SIZE];
	int          kernel [conv_pkg::NUM_TAPS];
	int          exp_q [$];
	logic        last_q [$];
	int          cycle_count = 0;
	int          latency_cycle = -1;
	int          results_seen = 0;
	int          exp_data;
	logic        exp_last;

	conv_top DUT (
		.clk         (clk),
		.reset       (reset),
		.weight_we   (weight_we),
		.weight_addr (weight_addr),
		.weight_data (weight_data),
		.pixel_valid (pixel_valid),
		.pixel_in    (pixel_in),
		.out_valid   (out_valid),
		.out_data    (out_data),
		.frame_done  (frame_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	// Taps at bits 16, 14, 13 and 11.
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Signed sum over the 3 by 3 window whose top-left pixel is (r, c).
	function automatic int conv_ref(input int r, input int c);
		int acc;
		acc = 0;
		for (int i = 0; i < conv_pkg::KERNEL_SIZE; i++)
			for (int j = 0; j < conv_pkg::KERNEL_SIZE; j++)
				acc += image[r+i][c+j] * kernel[i*conv_pkg::KERNEL_SIZE + j];
		return acc;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input int got, input int expected);
		if (got != expected)
			abort_run($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, expected));
	endtask

	task automatic idle(input int n);
		pixel_valid = 1'b0;
		weight_we   = 1'b0;
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic write_weight(input int addr, input int data);
		weight_we   = 1'b1;
		weight_addr = conv_pkg::WEIGHT_ADDR_WIDTH'(addr);
		weight_data = conv_pkg::WEIGHT_WIDTH'(data);
		@(posedge clk);
		#1;
		weight_we = 1'b0;
	endtask

	task automatic load_kernel(input bit all_min);
		logic [31:0] bits;
		for (int i = 0; i < conv_pkg::NUM_TAPS; i++)
		begin
			bits = random_bits(8);
			kernel[i] = all_min ? -128 : int'($signed(bits[7:0]));
			write_weight(i, kernel[i]);
		end
	endtask

	// Extreme frames use only the two end values of the pixel range.
	task automatic fill_image(input bit extreme);
		logic [31:0] bits;
		for (int r = 0; r < conv_pkg::IFM_SIZE; r++)
			for (int c = 0; c < conv_pkg::IFM_SIZE; c++)
			begin
				bits = extreme ? random_bits(1) : random_bits(8);
				if (extreme)
					image[r][c] = bits[0] ? 127 : -128;
				else
					image[r][c] = int'($signed(bits[7:0]));
			end
		for (int r = 0; r < conv_pkg::OFM_SIZE; r++)
			for (int c = 0; c < conv_pkg::OFM_SIZE; c++)
			begin
				exp_q.push_back(conv_ref(r, c));
				last_q.push_back(r == conv_pkg::OFM_SIZE - 1 && c == conv_pkg::OFM_SIZE - 1);
			end
	endtask

	task automatic send_frame(input bit extreme, input bit with_stalls, input bit time_first);
		fill_image(extreme);
		for (int r = 0; r < conv_pkg::IFM_SIZE; r++)
			for (int c = 0; c < conv_pkg::IFM_SIZE; c++)
			begin
				if (with_stalls)
					while (random_bits(1) == 1)
					begin
						pixel_valid = 1'b0;
						@(posedge clk);
						#1;
					end
				pixel_valid = 1'b1;
				pixel_in    = conv_pkg::PIXEL_WIDTH'(image[r][c]);
				// The next rising edge accepts this pixel.
				if (time_first && r == conv_pkg::KERNEL_SIZE - 1 && c == conv_pkg::KERNEL_SIZE - 1)
					latency_cycle = cycle_count + 1;
				@(posedge clk);
				#1;
			end
	endtask

	always @(negedge clk)
	begin
		if (out_valid)
		begin
			if (exp_q.size() == 0)
				abort_run("out_valid was high with no result expected");
			exp_data = exp_q.pop_front();
			exp_last = last_q.pop_front();
			check_value("out_data", int'(out_data), exp_data);
			check_value("frame_done", int'(frame_done), int'(exp_last));
			if (latency_cycle >= 0)
			begin
				check_value("first_result_cycle", cycle_count,
					latency_cycle + conv_pkg::CONV_LATENCY);
				latency_cycle = -1;
			end
			results_seen++;
		end
		else
		begin
			check_value("frame_done", int'(frame_done), 0);
			if (results_seen == 0)
				check_value("out_data", int'(out_data), 0);
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("timeout: the run did not finish in time");
	end

	initial
	begin
		reset       = 1'b1;
		weight_we   = 1'b0;
		weight_addr = '0;
		weight_data = '0;
		pixel_valid = 1'b0;
		pixel_in    = '0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		idle(4);

		load_kernel(1'b0);
		idle(2);
		send_frame(1'b0, 1'b0, 1'b1);
		idle(2);

		load_kernel(1'b0);
		send_frame(1'b0, 1'b1, 1'b0);
		idle(2);

		// Three frames with no gap between them.
		load_kernel(1'b0);
		send_frame(1'b0, 1'b0, 1'b0);
		send_frame(1'b0, 1'b0, 1'b0);
		send_frame(1'b0, 1'b0, 1'b0);
		idle(2);

		// Out-of-range index must leave the kernel as loaded.
		load_kernel(1'b1);
		write_weight(12, 8'h33);
		send_frame(1'b1, 1'b0, 1'b0);
		idle(1);

		// The last window leaves the adder tree a fixed latency after its pixel.
		repeat (conv_pkg::CONV_LATENCY + 4) @(posedge clk);

		if (exp_q.size() == 0 && results_seen == TOTAL_RESULTS)
		begin
			$display("STATUS: PASS");
			$finish;
		end
		else
			abort_run($sformatf("run ended with %0d results, %0d expected",
				results_seen, TOTAL_RESULTS));
	end

endmodule

// ==== conv.f ====
design/conv_pkg.sv
design/window_buffer.sv
design/weight_bank.sv
design/conv_ctrl.sv
design/conv_unit.sv
design/conv_top.sv
verif/conv_chk.sv
verif/conv_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = conv_tb
FILELIST = conv.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD)
